// File: access_check.sv
//////////////////////////////////////////////////////////////////////
// access control and page length checker, 11/34 rules
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module access_check
   import mmu_pkg::*;
(
   input  wire logic [6:0] va_page,
   input  wire cpu_mode_e  mode,
   input  wire logic       rd,
   input  wire logic       wr,
   input  wire logic       trap_odd,
   input  wire logic       mmu_on,
   pdr_if.user             pdr,
   fault_if.source         upd,
   output logic            abort,
   output logic            trap
);

   logic len_err;

   // expand-down pages grow from the top of the 8K segment
   assign len_err = pdr.ed ? (va_page < pdr.plf) : (va_page > pdr.plf);

   always_comb
   begin
      upd.update_pdr = 1'b0;
      upd.set_a      = 1'b0;
      upd.set_w      = 1'b0;
      upd.nonres     = 1'b0;
      upd.ple        = 1'b0;
      upd.ro         = 1'b0;
      upd.page       = 1'b0;
      abort          = 1'b0;
      trap           = 1'b0;

      if (mmu_on && (rd || wr))
      begin
         if (mode == mode_super)
         begin
            upd.nonres = 1'b1;
            upd.page   = 1'b1;
            abort      = 1'b1;
         end
         else if (wr)
         begin
            case (pdr.acf)
               ro_trap, ro:
               begin
                  upd.update_pdr = 1'b1;
                  upd.page       = 1'b1;
                  upd.ro         = 1'b1;
                  upd.ple        = len_err;
                  abort          = 1'b1;
               end
               rw_trap, rw_trap_w:
               begin
                  upd.update_pdr = 1'b1;
                  upd.set_a      = 1'b1;
                  upd.nonres     = 1'b1;
                  upd.page       = 1'b1;
                  trap           = 1'b1;
               end
               rw:
               begin
                  upd.update_pdr = 1'b1;
                  upd.page       = 1'b1;
                  // odd address trap cycles leave W alone
                  upd.set_w      = ~trap_odd;
                  upd.ple        = len_err;
                  trap           = len_err;
               end
               default:
               begin
                  upd.update_pdr = 1'b1;
                  upd.page       = 1'b1;
                  upd.nonres     = 1'b1;
                  upd.ple        = len_err;
                  abort          = 1'b1;
               end
            endcase
         end
         else
         begin
            case (pdr.acf)
               non_res, unused3, unused7:
               begin
                  upd.nonres = 1'b1;
                  upd.page   = 1'b1;
                  upd.ple    = len_err;
                  abort      = 1'b1;
               end
               rw_trap, rw_trap_w:
               begin
                  upd.update_pdr = 1'b1;
                  upd.set_a      = 1'b1;
                  upd.nonres     = 1'b1;
                  upd.page       = 1'b1;
                  trap           = 1'b1;
               end
               default:
               begin
                  // resident page, only the length can fail
                  upd.page = 1'b1;
                  upd.ple  = len_err;
                  abort    = len_err;
               end
            endcase
         end
      end
   end

   // the cpu takes at most one of the two per access
   always_comb
   begin
      a_abort_trap_excl: assert (!(abort && trap))
         else $error("abort and trap raised together");
   end

endmodule

`default_nettype wire

// File: addr_translate.sv
//////////////////////////////////////////////////////////////////////
// page index and 18 bit physical address with I/O page fold
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module addr_translate
   import mmu_pkg::*;
(
   input  wire logic [15:0] va,
   input  wire cpu_mode_e   mode,
   input  wire logic        i_access,
   input  wire logic        d_access,
   input  wire logic        trap_cycle,
   input  wire logic [2:0]  mmr3_id,
   input  wire logic        mmu_on,
   input  wire logic        maint_mode,
   input  wire logic [15:0] par,
   output logic [5:0]       pxr_index,
   output logic [21:0]      pa
);

   cpu_mode_e   eff_mode;
   logic        d_space_en;
   logic [21:0] map_sum;
   logic [17:0] map_18;
   logic [21:0] mapped_pa;
   logic [21:0] unmapped_pa;
   logic        map_address;

   // vector fetches always go through the kernel map
   assign eff_mode = trap_cycle ? mode_kernel : mode;

   always_comb
   begin
      case (eff_mode)
         mode_kernel: d_space_en = mmr3_id[2];
         mode_super:  d_space_en = mmr3_id[1];
         mode_user:   d_space_en = mmr3_id[0];
         default:     d_space_en = 1'b0;
      endcase
   end

   // {mode, i/d, apf}
   assign pxr_index = {eff_mode, d_space_en & ~i_access, va[15:13]};

   // par is in 64 byte blocks
   assign map_sum = {par, 6'b0} + {9'b0, va[12:0]};
   assign map_18  = map_sum[17:0];

   assign mapped_pa = (map_18[17:13] == 5'b11111) ? {iopage_prefix, map_18[15:0]} :
                                                    {4'b0, map_18};

   assign unmapped_pa = (va[15:13] == 3'b111) ? {iopage_prefix, va} : {6'b0, va};

   // maintenance mode maps destination accesses only
   assign map_address = mmu_on | (maint_mode & d_access);

   assign pa = map_address ? mapped_pa : unmapped_pa;

endmodule

`default_nettype wire

// File: all.f
mmu_pkg.sv
mmu_if.sv
pxr_file.sv
mmu_status.sv
access_check.sv
addr_translate.sv
mmu_top.sv
tb_clock.sv
mmu_tb.sv

// File: mmu_if.sv
//////////////////////////////////////////////////////////////////////
// page descriptor bus and fault update strobes between mmu blocks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

// descriptor of the page selected by the current access
interface pdr_if
   import mmu_pkg::*;
   ();
   acf_e       acf;
   logic [6:0] plf;
   logic       ed;
   logic       w;

   modport owner (output acf, plf, ed, w);
   modport user  (input acf, plf, ed, w);
endinterface

// levels valid during the access, acted on at the next edge
interface fault_if;
   logic       update_pdr;
   logic       set_a;
   logic       set_w;
   logic       nonres;
   logic       ple;
   logic       ro;
   logic       page;

   modport source (output update_pdr, set_a, set_w, nonres, ple, ro, page);
   modport sink   (input update_pdr, set_a, set_w, nonres, ple, ro, page);
endinterface

`default_nettype wire

// File: mmu_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared types and constants for the KT-11 style memory management unit
// cpu modes, access control codes, register selects, masks and bit fields
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mmu_pkg;

   // psw current mode encoding
   typedef enum logic [1:0] {
      mode_kernel  = 2'b00,
      mode_super   = 2'b01,
      mode_illegal = 2'b10,
      mode_user    = 2'b11
   } cpu_mode_e;

   // pdr access control field
   typedef enum logic [2:0] {
      non_res   = 3'd0,
      ro_trap   = 3'd1,
      ro        = 3'd2,
      unused3   = 3'd3,
      rw_trap   = 3'd4,
      rw_trap_w = 3'd5,
      rw        = 3'd6,
      unused7   = 3'd7
   } acf_e;

   // register port target, from address bits 7:6 and 1:0
   typedef enum logic [2:0] {
      sel_pdr,
      sel_par,
      sel_mmr0,
      sel_mmr2,
      sel_mmr3,
      sel_none
   } reg_sel_e;

   // acf bit 0 does not exist on the 11/34
   localparam logic [15:0] pdr_rd_mask    = 16'o077716;
   localparam logic [7:0]  pdr_wr_mask_hi = 8'o177;
   localparam logic [7:0]  pdr_wr_mask_lo = 8'o016;
   localparam logic [15:0] par_mask       = 16'o007777;
   localparam logic [5:0]  iopage_prefix  = 6'o77;

   // status register 0 bit positions
   localparam int mmr0_nonres_bit = 15;
   localparam int mmr0_ple_bit    = 14;
   localparam int mmr0_ro_bit     = 13;
   localparam int mmr0_maint_bit  = 8;
   localparam int mmr0_enable_bit = 0;

endpackage

`default_nettype wire

// File: mmu_status.sv
//////////////////////////////////////////////////////////////////////
// status registers 0, 2 and 3
// fault latching and live readback of status register 0
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mmu_status
   import mmu_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        local_reset,
   input  wire logic        reg_wr,
   input  wire reg_sel_e    sel,
   input  wire logic [1:0]  reg_be,
   input  wire logic [15:0] reg_wdata,
   input  wire logic [15:0] va,
   input  wire cpu_mode_e   mode,
   input  wire logic        fetch_va,
   fault_if.sink            upd,
   output logic [15:0]      mmr0,
   output logic [15:0]      mmr0_live,
   output logic [15:0]      mmr2,
   output logic [15:0]      mmr3,
   output logic             mmu_on,
   output logic             maint_mode
);

   logic fault;
   logic latch;

   // any of the abort flags freezes register 0 and register 2
   assign fault = mmr0[mmr0_nonres_bit] | mmr0[mmr0_ple_bit] | mmr0[mmr0_ro_bit];
   assign latch = (upd.nonres | upd.ple | upd.ro | upd.page) & ~fault;

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr0 <= '0;
      else if (reg_wr)
      begin
         if (sel == sel_mmr0)
         begin
            if (reg_be[1])
               mmr0[15:8] <= reg_wdata[15:8];
            if (reg_be[0])
               mmr0[7:0] <= reg_wdata[7:0];
         end
      end
      else if (latch)
      begin
         if (upd.nonres)
            mmr0[mmr0_nonres_bit] <= 1'b1;
         if (upd.ple)
            mmr0[mmr0_ple_bit] <= 1'b1;
         if (upd.ro)
            mmr0[mmr0_ro_bit] <= 1'b1;
         // mode and page of the faulting access
         if (upd.page)
         begin
            mmr0[6:5] <= mode;
            mmr0[3:1] <= va[15:13];
         end
      end
   end

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr3 <= '0;
      else if (reg_wr && sel == sel_mmr3)
         mmr3 <= reg_wdata;
   end

   // tracks the instruction address, no super mode on the 11/34
   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
         mmr2 <= '0;
      else if (fetch_va && !fault && mode != mode_super)
         mmr2 <= va;
   end

   // without a fault, show the mode and page of the current access
   assign mmr0_live = (fault || !mmu_on) ? mmr0 :
                      {mmr0[15:7], mode, mmr0[4], va[15:13], mmr0[0]};

   assign mmu_on     = mmr0[mmr0_enable_bit];
   assign maint_mode = mmr0[mmr0_maint_bit];

   // fault strobes come only from mapped accesses
   a_upd_needs_mmu_on: assert property (@(posedge clk) disable iff (local_reset)
      (upd.page || upd.nonres || upd.ple || upd.ro) |-> mmu_on)
      else $error("fault strobe while mapping is off");

endmodule

`default_nettype wire

// File: mmu_tb.sv
//////////////////////////////////////////////////////////////////////
// mmu testbench with reference model, stimulus tasks and compare process
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mmu_tb
   import mmu_pkg::*;
();

   // the tests take roughly 520 cycles
   localparam int max_cycles = 4000;

   typedef struct packed {
      logic [21:0] pa;
      logic        abort;
      logic        trap;
      logic [15:0] mmr0;
      logic [5:0]  idx;
      logic [15:0] pdr;
   } ref_t;

   logic        clk;
   logic        local_reset;
   logic [15:0] va;
   cpu_mode_e   mode;
   logic        rd;
   logic        wr;
   logic        i_access;
   logic        d_access;
   logic        trap_cycle;
   logic        fetch_va;
   logic        trap_odd;
   logic [21:0] pa;
   logic        abort;
   logic        trap;
   logic        reg_wr;
   logic        reg_rd;
   logic [1:0]  reg_be;
   logic [7:0]  reg_addr;
   logic [15:0] reg_wdata;
   logic [15:0] reg_rdata;

   // model state
   logic [15:0] par_m [64];
   logic [15:0] pdr_m [64];
   logic [15:0] mmr0_m;
   logic [15:0] mmr2_m;
   logic [15:0] mmr3_m;

   // what the compare process expects this cycle
   int          chk_kind;
   logic [21:0] exp_pa;
   logic        exp_abort;
   logic        exp_trap;
   logic [15:0] exp_rdata;

   string       test_name;
   int          check_count;
   int          error_count;
   int          test_checks0;
   int          test_errors0;
   int          cycle_count = 0;
   integer      seed;
   logic [31:0] rv;
   logic [31:0] rv2;

   tb_clock u_clock (
      .clk         (clk),
      .local_reset (local_reset)
   );

   mmu_top uut (
      .clk         (clk),
      .local_reset (local_reset),
      .va          (va),
      .mode        (mode),
      .rd          (rd),
      .wr          (wr),
      .i_access    (i_access),
      .d_access    (d_access),
      .trap_cycle  (trap_cycle),
      .fetch_va    (fetch_va),
      .trap_odd    (trap_odd),
      .pa          (pa),
      .abort       (abort),
      .trap        (trap),
      .reg_wr      (reg_wr),
      .reg_rd      (reg_rd),
      .reg_be      (reg_be),
      .reg_addr    (reg_addr),
      .reg_wdata   (reg_wdata),
      .reg_rdata   (reg_rdata)
   );

   // expected result of one access against the model state
   function automatic ref_t mmu_ref(input logic [15:0] a, input logic [1:0] m,
                                    input logic r, input logic w, input logic ia,
                                    input logic da, input logic tc, input logic todd);
      ref_t        res;
      logic [1:0]  em;
      logic        id_bit;
      logic [17:0] phys;
      logic [15:0] d;
      logic [6:0]  blk;
      logic        len;
      logic        nr;
      logic        pl;
      logic        rof;
      logic        sa;
      logic        sw;
      logic        upd;

      em = tc ? 2'd0 : m;
      case (em)
         2'd0:    id_bit = mmr3_m[2];
         2'd1:    id_bit = mmr3_m[1];
         2'd3:    id_bit = mmr3_m[0];
         default: id_bit = 1'b0;
      endcase
      res.idx = {em, id_bit & ~ia, a[15:13]};

      if (mmr0_m[0] || (mmr0_m[8] && da))
      begin
         phys = {par_m[res.idx][11:0], 6'b0} + {5'b0, a[12:0]};
         if (phys >= 18'o760000)
            res.pa = {6'o77, phys[15:0]};
         else
            res.pa = {4'b0, phys};
      end
      else if (a >= 16'o160000)
         res.pa = {6'o77, a};
      else
         res.pa = {6'b0, a};

      d   = pdr_m[res.idx];
      blk = a[12:6];
      len = d[3] ? (blk < d[14:8]) : (blk > d[14:8]);
      nr  = 1'b0;
      pl  = 1'b0;
      rof = 1'b0;
      sa  = 1'b0;
      sw  = 1'b0;
      upd = 1'b0;
      res.abort = 1'b0;
      res.trap  = 1'b0;

      if (mmr0_m[0] && (r || w))
      begin
         if (m == 2'd1)
         begin
            nr = 1'b1;
            res.abort = 1'b1;
         end
         else if (w)
         begin
            upd = 1'b1;
            case (d[2:0])
               3'd1, 3'd2:
               begin
                  rof = 1'b1;
                  pl = len;
                  res.abort = 1'b1;
               end
               3'd4, 3'd5:
               begin
                  sa = 1'b1;
                  nr = 1'b1;
                  res.trap = 1'b1;
               end
               3'd6:
               begin
                  sw = !todd;
                  pl = len;
                  res.trap = len;
               end
               default:
               begin
                  nr = 1'b1;
                  pl = len;
                  res.abort = 1'b1;
               end
            endcase
         end
         else
         begin
            case (d[2:0])
               3'd4, 3'd5:
               begin
                  upd = 1'b1;
                  sa = 1'b1;
                  nr = 1'b1;
                  res.trap = 1'b1;
               end
               3'd1, 3'd2, 3'd6:
               begin
                  pl = len;
                  res.abort = len;
               end
               default:
               begin
                  nr = 1'b1;
                  pl = len;
                  res.abort = 1'b1;
               end
            endcase
         end
      end

      // register 0 follows every mapped access until a fault freezes it
      res.mmr0 = mmr0_m;
      if (mmr0_m[0] && (r || w) && mmr0_m[15:13] == 3'b000)
      begin
         res.mmr0[15:13] = {nr, pl, rof};
         res.mmr0[6:5] = m;
         res.mmr0[3:1] = a[15:13];
      end

      res.pdr = d;
      if (upd)
      begin
         res.pdr[7] = d[7] | sa;
         res.pdr[6] = d[6] | sw;
      end
      return res;
   endfunction

   function automatic logic [15:0] expected_rdata(input logic [7:0] addr);
      logic [15:0] live;

      live = mmr0_m;
      if (mmr0_m[0] && mmr0_m[15:13] == 3'b000)
      begin
         live[6:5] = mode;
         live[3:1] = va[15:13];
      end
      case (addr[7:6])
         2'b00:   return pdr_m[addr[5:0]] & 16'o077716;
         2'b01:   return par_m[addr[5:0]] & 16'o007777;
         2'b10:
         begin
            case (addr[1:0])
               2'b00:   return live;
               2'b10:   return mmr2_m;
               2'b11:   return mmr3_m;
               default: return 16'h0000;
            endcase
         end
         default: return 16'h0000;
      endcase
   endfunction

   task automatic drive_idle();
      va = 16'h0000;
      mode = mode_kernel;
      rd = 1'b0;
      wr = 1'b0;
      i_access = 1'b0;
      d_access = 1'b0;
      trap_cycle = 1'b0;
      fetch_va = 1'b0;
      trap_odd = 1'b0;
      reg_wr = 1'b0;
      reg_rd = 1'b0;
      reg_be = 2'b00;
      reg_addr = 8'h00;
      reg_wdata = 16'h0000;
      chk_kind = 0;
   endtask

   // one access cycle, model updated at the edge that ends it
   task automatic access(input logic [15:0] a, input cpu_mode_e m, input logic r,
                         input logic w, input logic ia, input logic tc,
                         input logic fv, input logic todd);
      ref_t res;

      va = a;
      mode = m;
      rd = r;
      wr = w;
      i_access = ia;
      d_access = ~ia;
      trap_cycle = tc;
      fetch_va = fv;
      trap_odd = todd;
      res = mmu_ref(a, m, r, w, ia, ~ia, tc, todd);
      exp_pa = res.pa;
      exp_abort = res.abort;
      exp_trap = res.trap;
      chk_kind = 1;
      @(posedge clk);
      if (fv && mmr0_m[15:13] == 3'b000 && m != mode_super)
         mmr2_m = a;
      mmr0_m = res.mmr0;
      pdr_m[res.idx] = res.pdr;
      #1;
      drive_idle();
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [1:0] be,
                            input logic [15:0] data);
      reg_wr = 1'b1;
      reg_be = be;
      reg_addr = addr;
      reg_wdata = data;
      @(posedge clk);
      case (addr[7:6])
         2'b00:
         begin
            if (be[1])
               pdr_m[addr[5:0]][15:8] = data[15:8] & 8'o177;
            if (be[0])
               pdr_m[addr[5:0]][7:0] = data[7:0] & 8'o016;
         end
         2'b01:
         begin
            if (be[1])
               par_m[addr[5:0]][15:8] = data[15:8];
            if (be[0])
               par_m[addr[5:0]][7:0] = data[7:0];
         end
         2'b10:
         begin
            // register 3 is always written as a whole word
            if (addr[1:0] == 2'b00 && be[1])
               mmr0_m[15:8] = data[15:8];
            if (addr[1:0] == 2'b00 && be[0])
               mmr0_m[7:0] = data[7:0];
            if (addr[1:0] == 2'b11)
               mmr3_m = data;
         end
         default:
         begin
         end
      endcase
      #1;
      drive_idle();
   endtask

   task automatic reg_read(input logic [7:0] addr);
      reg_rd = 1'b1;
      reg_addr = addr;
      exp_rdata = expected_rdata(addr);
      chk_kind = 2;
      @(posedge clk);
      #1;
      drive_idle();
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_checks0 = check_count;
      test_errors0 = error_count;
   endtask

   task automatic finish_test();
      $display("test %s: %0d checks, %0d errors", test_name,
               check_count - test_checks0, error_count - test_errors0);
   endtask

   // compare just before the next rising edge
   always
   begin
      @(posedge clk);
      #7;
      if (chk_kind == 1)
      begin
         check_count += 3;
         assert (pa === exp_pa)
         else
         begin
            $display("** Error %s: pa expected %o, got %o", test_name, exp_pa, pa);
            error_count++;
         end
         assert ({abort, trap} === {exp_abort, exp_trap})
         else
         begin
            $display("** Error %s: abort/trap expected %b%b, got %b%b", test_name,
                     exp_abort, exp_trap, abort, trap);
            error_count++;
         end
         // register port is idle during an access
         assert (reg_rdata === 16'h0000)
         else
         begin
            $display("** Error %s: idle reg_rdata expected %o, got %o", test_name,
                     16'h0000, reg_rdata);
            error_count++;
         end
      end
      else if (chk_kind == 2)
      begin
         check_count++;
         assert (reg_rdata === exp_rdata)
         else
         begin
            $display("** Error %s: reg_rdata at %o expected %o, got %o", test_name,
                     reg_addr, exp_rdata, reg_rdata);
            error_count++;
         end
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= max_cycles)
      begin
         $display("timeout: the run did not finish within %0d cycles", max_cycles);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   initial
   begin
      seed = 31;
      drive_idle();
      check_count = 0;
      error_count = 0;
      mmr0_m = 16'h0000;
      mmr2_m = 16'h0000;
      mmr3_m = 16'h0000;
      for (int i = 0; i < 64; i++)
      begin
         par_m[i] = 16'h0000;
         pdr_m[i] = 16'h0000;
      end
      @(negedge local_reset);
      @(posedge clk);
      #1;

      start_test("unmapped");
      for (int k = 0; k < 100; k++)
      begin
         rv = $random(seed);
         access(rv[15:0], rv[16] ? mode_user : mode_kernel, rv[17], ~rv[17], rv[18],
                rv[19], rv[17] & rv[18], 1'b0);
      end
      finish_test();

      start_test("pxr_rw");
      for (int k = 0; k < 64; k++)
      begin
         rv = $random(seed);
         rv2 = $random(seed);
         reg_write({1'b0, rv[2], rv[8:3]}, rv[10:9], rv2[15:0]);
         reg_read({1'b0, rv[2], rv[8:3]});
      end
      finish_test();

      // every page rw at full length, page 7 on the I/O page
      start_test("mapped");
      for (int i = 0; i < 64; i++)
      begin
         rv = $random(seed);
         if (i % 8 == 7)
            reg_write({2'b01, 6'(i)}, 2'b11, 16'o007600);
         else
            reg_write({2'b01, 6'(i)}, 2'b11, rv[15:0]);
         reg_write({2'b00, 6'(i)}, 2'b11, 16'o077406);
      end
      reg_write(8'h83, 2'b11, 16'o000005);
      reg_write(8'h80, 2'b11, 16'o000001);
      for (int k = 0; k < 100; k++)
      begin
         rv = $random(seed);
         access(rv[15:0], rv[16] ? mode_user : mode_kernel, rv[17], ~rv[17], rv[18],
                rv[19] & rv[20], rv[17] & rv[18], 1'b0);
      end
      finish_test();

      start_test("abort");
      // user I page 2 non-resident, kernel I page 3 read-only
      reg_write(8'o062, 2'b11, 16'o077400);
      reg_write(8'o003, 2'b11, 16'o077402);
      reg_write(8'h80, 2'b11, 16'o000001);
      access(16'o040124, mode_user, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'h80);
      access(16'o060010, mode_kernel, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'h80);
      // user I page 4 with length 010, expand-up
      reg_write(8'o064, 2'b11, 16'o004006);
      reg_write(8'h80, 2'b11, 16'o000001);
      access(16'o102400, mode_user, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'h80);
      reg_write(8'h80, 2'b11, 16'o000001);
      for (int k = 0; k < 16; k++)
      begin
         rv = $random(seed);
         access({3'o4, rv[6:0], rv[12:7]}, mode_user, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      end
      reg_read(8'h80);
      finish_test();

      start_test("trap_aw");
      reg_write(8'o005, 2'b11, 16'o077404);
      reg_write(8'h80, 2'b11, 16'o000001);
      access(16'o120000, mode_kernel, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'o005);
      reg_read(8'h80);
      reg_write(8'h80, 2'b11, 16'o000001);
      reg_write(8'o006, 2'b11, 16'o077406);
      access(16'o140002, mode_kernel, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
      reg_read(8'o006);
      access(16'o140002, mode_kernel, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'o006);
      // kernel I page 1 expand-down from block 0100
      reg_write(8'o001, 2'b11, 16'o040016);
      access(16'o021000, mode_kernel, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
      reg_read(8'o001);
      reg_read(8'h80);
      finish_test();

      start_test("super_mmr2");
      reg_write(8'h80, 2'b11, 16'o000001);
      access(16'o012345, mode_kernel, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
      access(16'o034000, mode_super, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
      reg_read(8'h82);
      access(16'o054321, mode_kernel, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
      reg_read(8'h82);
      reg_read(8'h80);
      finish_test();

      $display("total: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: mmu_top.sv
//////////////////////////////////////////////////////////////////////
// mmu top level, register decode and read data mux
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module mmu_top
   import mmu_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        local_reset,
   input  wire logic [15:0] va,
   input  wire cpu_mode_e   mode,
   input  wire logic        rd,
   input  wire logic        wr,
   input  wire logic        i_access,
   input  wire logic        d_access,
   input  wire logic        trap_cycle,
   input  wire logic        fetch_va,
   input  wire logic        trap_odd,
   output logic [21:0]      pa,
   output logic             abort,
   output logic             trap,
   input  wire logic        reg_wr,
   input  wire logic        reg_rd,
   input  wire logic [1:0]  reg_be,
   input  wire logic [7:0]  reg_addr,
   input  wire logic [15:0] reg_wdata,
   output logic [15:0]      reg_rdata
);

   reg_sel_e    sel;
   logic [5:0]  pxr_index;
   logic [15:0] par;
   logic [15:0] reg_par;
   logic [15:0] reg_pdr;
   logic [15:0] mmr0_live;
   logic [15:0] mmr2;
   logic [15:0] mmr3;
   logic        mmu_on;
   logic        maint_mode;

   pdr_if   pdr_bus ();
   fault_if fault_bus ();

   // bit 7 selects status registers, bit 6 selects PAR over PDR
   always_comb
   begin
      case (reg_addr[7:6])
         2'b00: sel = sel_pdr;
         2'b01: sel = sel_par;
         2'b10:
         begin
            case (reg_addr[1:0])
               2'b00:   sel = sel_mmr0;
               2'b10:   sel = sel_mmr2;
               2'b11:   sel = sel_mmr3;
               default: sel = sel_none;
            endcase
         end
         default: sel = sel_none;
      endcase
   end

   addr_translate u_translate (
      .va         (va),
      .mode       (mode),
      .i_access   (i_access),
      .d_access   (d_access),
      .trap_cycle (trap_cycle),
      .mmr3_id    (mmr3[2:0]),
      .mmu_on     (mmu_on),
      .maint_mode (maint_mode),
      .par        (par),
      .pxr_index  (pxr_index),
      .pa         (pa)
   );

   pxr_file u_pxr (
      .clk         (clk),
      .local_reset (local_reset),
      .reg_wr      (reg_wr),
      .sel         (sel),
      .reg_be      (reg_be),
      .reg_index   (reg_addr[5:0]),
      .reg_wdata   (reg_wdata),
      .pxr_index   (pxr_index),
      .mmu_on      (mmu_on),
      .pdr         (pdr_bus.owner),
      .upd         (fault_bus.sink),
      .par         (par),
      .reg_par     (reg_par),
      .reg_pdr     (reg_pdr)
   );

   access_check u_check (
      .va_page  (va[12:6]),
      .mode     (mode),
      .rd       (rd),
      .wr       (wr),
      .trap_odd (trap_odd),
      .mmu_on   (mmu_on),
      .pdr      (pdr_bus.user),
      .upd      (fault_bus.source),
      .abort    (abort),
      .trap     (trap)
   );

   mmu_status u_status (
      .clk         (clk),
      .local_reset (local_reset),
      .reg_wr      (reg_wr),
      .sel         (sel),
      .reg_be      (reg_be),
      .reg_wdata   (reg_wdata),
      .va          (va),
      .mode        (mode),
      .fetch_va    (fetch_va),
      .upd         (fault_bus.sink),
      .mmr0        (),
      .mmr0_live   (mmr0_live),
      .mmr2        (mmr2),
      .mmr3        (mmr3),
      .mmu_on      (mmu_on),
      .maint_mode  (maint_mode)
   );

   always_comb
   begin
      reg_rdata = '0;
      if (reg_rd)
      begin
         case (sel)
            sel_pdr:  reg_rdata = reg_pdr & pdr_rd_mask;
            sel_par:  reg_rdata = reg_par & par_mask;
            sel_mmr0: reg_rdata = mmr0_live;
            sel_mmr2: reg_rdata = mmr2;
            sel_mmr3: reg_rdata = mmr3;
            default:  reg_rdata = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: pxr_file.sv
//////////////////////////////////////////////////////////////////////
// 64 entry PAR and PDR register files
// byte writes from the register port, A and W bit updates from accesses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module pxr_file
   import mmu_pkg::*;
(
   input  wire logic        clk,
   input  wire logic        local_reset,
   input  wire logic        reg_wr,
   input  wire reg_sel_e    sel,
   input  wire logic [1:0]  reg_be,
   input  wire logic [5:0]  reg_index,
   input  wire logic [15:0] reg_wdata,
   input  wire logic [5:0]  pxr_index,
   input  wire logic        mmu_on,
   pdr_if.owner             pdr,
   fault_if.sink            upd,
   output logic [15:0]      par,
   output logic [15:0]      reg_par,
   output logic [15:0]      reg_pdr
);

   logic [7:0] par_hi [64];
   logic [7:0] par_lo [64];
   logic [7:0] pdr_hi [64];
   logic [7:0] pdr_lo [64];

   always_ff @(posedge clk or posedge local_reset)
   begin
      if (local_reset)
      begin
         for (int i = 0; i < 64; i++)
         begin
            par_hi[i] <= '0;
            par_lo[i] <= '0;
            pdr_hi[i] <= '0;
            pdr_lo[i] <= '0;
         end
      end
      else if (reg_wr)
      begin
         if (sel == sel_par)
         begin
            if (reg_be[1])
               par_hi[reg_index] <= reg_wdata[15:8];
            if (reg_be[0])
               par_lo[reg_index] <= reg_wdata[7:0];
         end
         else if (sel == sel_pdr)
         begin
            // a low byte write also clears A and W
            if (reg_be[1])
               pdr_hi[reg_index] <= reg_wdata[15:8] & pdr_wr_mask_hi;
            if (reg_be[0])
               pdr_lo[reg_index] <= reg_wdata[7:0] & pdr_wr_mask_lo;
         end
      end
      else if (mmu_on && upd.update_pdr)
      begin
         pdr_lo[pxr_index] <= pdr_lo[pxr_index] | {upd.set_a, upd.set_w, 6'b0};
      end
   end

   // translation side
   assign par = {par_hi[pxr_index], par_lo[pxr_index]} & par_mask;

   // acf bit 0 is never written, so it always reads zero
   assign pdr.acf = acf_e'(pdr_lo[pxr_index][2:0]);
   assign pdr.plf = pdr_hi[pxr_index][6:0];
   assign pdr.ed  = pdr_lo[pxr_index][3];
   assign pdr.w   = pdr_lo[pxr_index][6];

   // register port side, masked at the top level
   assign reg_par = {par_hi[reg_index], par_lo[reg_index]};
   assign reg_pdr = {pdr_hi[reg_index], pdr_lo[reg_index]};

   // the checker must request a pdr update whenever it sets A or W
   a_aw_needs_update: assert property (@(posedge clk) disable iff (local_reset)
      (upd.set_a || upd.set_w) |-> upd.update_pdr)
      else $error("A/W strobe without update_pdr");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module mmu_tb -o mmu_sim
./obj_dir/mmu_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// File: tb_clock.sv
//////////////////////////////////////////////////////////////////////
// testbench clock, 8 ns period, and power-on reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock
(
   output logic clk,
   output logic local_reset
);

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // reset held for three rising edges
   initial
   begin
      local_reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      local_reset = 1'b0;
   end

endmodule

`default_nettype wire
